//--- hdl/mbox_pkg.sv
package mbox_pkg;

  // Word and buffer sizing
  localparam int DATA_WIDTH  = 32;
  localparam int FIFO_DEPTH  = 16;
  localparam int COUNT_WIDTH = 5;  // Holds 0 to FIFO_DEPTH inclusive
  localparam int PTR_WIDTH   = 4;  // Indexes FIFO_DEPTH entries

  // AXI response codes, only the two this block returns
  typedef enum logic [1:0] {
    OKAY   = 2'd0,
    SLVERR = 2'd2
  } resp_e;

  // Write request from the master, no address bits since there is one port
  typedef struct packed {
    logic                  awvalid;
    logic                  wvalid;
    logic [DATA_WIDTH-1:0] wdata;
    logic                  bready;
  } axil_wr_req_t;

  // Write response back to the master
  typedef struct packed {
    logic  awready;
    logic  wready;
    logic  bvalid;
    resp_e bresp;
  } axil_wr_rsp_t;

  // Read request from the master
  typedef struct packed {
    logic arvalid;
    logic rready;
  } axil_rd_req_t;

  // Read response back to the master
  typedef struct packed {
    logic                  arready;
    logic                  rvalid;
    logic [DATA_WIDTH-1:0] rdata;
    resp_e                 rresp;
  } axil_rd_rsp_t;

  // One stream beat, tready runs as a separate wire the other way
  typedef struct packed {
    logic                  tvalid;
    logic [DATA_WIDTH-1:0] tdata;
  } axis_beat_t;

endpackage

//--- hdl/axi_axis_writer.sv
module axi_axis_writer
  import mbox_pkg::*;
(
  input  logic         aclk,
  input  logic         aresetn,

  // AXI4-Lite write channels
  input  axil_wr_req_t wr_req,
  output axil_wr_rsp_t wr_rsp,

  // Stream push into the FIFO
  output axis_beat_t   push_beat,
  input  logic         push_ready   // FIFO not full
);

  logic                  accept_q, accept_d;  // awready/wready pulse
  logic                  bvalid_q, bvalid_d;  // Response pending
  logic                  push_q, push_d;      // One-cycle push strobe
  resp_e                 bresp_q, bresp_d;
  logic [DATA_WIDTH-1:0] data_q;
  logic                  wr_accept;

  // Address and data arrive together; only one write is in flight at a time
  assign wr_accept = wr_req.awvalid & wr_req.wvalid & ~bvalid_q;

  always_ff @(posedge aclk)
  begin
    if (!aresetn)
    begin
      accept_q <= 1'b0;
      bvalid_q <= 1'b0;
      push_q   <= 1'b0;
      bresp_q  <= OKAY;
    end
    else
    begin
      accept_q <= accept_d;
      bvalid_q <= bvalid_d;
      push_q   <= push_d;
      bresp_q  <= bresp_d;
    end
  end

  // Word is held for the push cycle that follows acceptance
  always_ff @(posedge aclk)
  begin
    if (wr_accept)
    begin
      data_q <= wr_req.wdata;
    end
  end

  always_comb
  begin
    accept_d = wr_accept;               // Ready is high for exactly one cycle
    push_d   = wr_accept & push_ready;  // No push if FIFO was full at accept
    bvalid_d = bvalid_q;
    bresp_d  = bresp_q;

    if (wr_accept)
    begin
      bvalid_d = 1'b1;
      // Full buffer refuses the word, it is dropped here
      bresp_d  = push_ready ? OKAY : SLVERR;
    end
    else if (bvalid_q & wr_req.bready)
    begin
      bvalid_d = 1'b0;
    end
  end

  // Only the writer fills the FIFO, so space seen at accept still holds here
  assign push_beat.tvalid = push_q;
  assign push_beat.tdata  = data_q;

  assign wr_rsp.awready = accept_q;
  assign wr_rsp.wready  = accept_q;
  assign wr_rsp.bvalid  = bvalid_q;
  assign wr_rsp.bresp   = bresp_q;

endmodule

//--- hdl/axis_fifo.sv
module axis_fifo
  import mbox_pkg::*;
(
  input  logic                   aclk,
  input  logic                   aresetn,

  // Write side
  input  axis_beat_t             push_beat,
  output logic                   push_ready,

  // Read side, first word falls through
  output axis_beat_t             pop_beat,
  input  logic                   pop_ready,

  output logic [COUNT_WIDTH-1:0] fill_count
);

  logic [DATA_WIDTH-1:0]  mem [FIFO_DEPTH];
  logic [PTR_WIDTH-1:0]   wr_ptr_q;
  logic [PTR_WIDTH-1:0]   rd_ptr_q;
  logic [COUNT_WIDTH-1:0] count_q;
  logic                   full;
  logic                   empty;
  logic                   do_push;
  logic                   do_pop;

  // Status comes straight from the occupancy counter
  assign full  = (count_q == COUNT_WIDTH'(FIFO_DEPTH));
  assign empty = (count_q == '0);

  assign do_push = push_beat.tvalid & ~full;
  assign do_pop  = pop_ready & ~empty;

  // Storage array
  always_ff @(posedge aclk)
  begin
    if (do_push)
    begin
      mem[wr_ptr_q] <= push_beat.tdata;
    end
  end

  always_ff @(posedge aclk)
  begin
    if (!aresetn)
    begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end
    else
    begin
      if (do_push)
      begin
        // Wrap at the last entry
        wr_ptr_q <= (wr_ptr_q == PTR_WIDTH'(FIFO_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end

      if (do_pop)
      begin
        rd_ptr_q <= (rd_ptr_q == PTR_WIDTH'(FIFO_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end

      // Push and pop together leave the level unchanged
      case ({do_push, do_pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  assign push_ready = ~full;

  // Head word is presented without a register stage
  assign pop_beat.tvalid = ~empty;
  assign pop_beat.tdata  = mem[rd_ptr_q];

  assign fill_count = count_q;

endmodule

//--- hdl/axi_axis_reader.sv
module axi_axis_reader
  import mbox_pkg::*;
(
  input  logic         aclk,
  input  logic         aresetn,

  // AXI4-Lite read channels
  input  axil_rd_req_t rd_req,
  output axil_rd_rsp_t rd_rsp,

  // Stream head from the FIFO
  input  axis_beat_t   pop_beat,
  output logic         pop_ready
);

  logic                  ready_q, ready_d;  // Drives arready and the pop
  logic                  valid_q, valid_d;
  logic [DATA_WIDTH-1:0] rdata_q, rdata_d;
  logic                  rd_accept;

  // A new read waits until the previous data has been taken
  assign rd_accept = rd_req.arvalid & ~valid_q;

  always_ff @(posedge aclk)
  begin
    if (!aresetn)
    begin
      ready_q <= 1'b0;
      valid_q <= 1'b0;
      rdata_q <= '0;
    end
    else
    begin
      ready_q <= ready_d;
      valid_q <= valid_d;
      rdata_q <= rdata_d;
    end
  end

  always_comb
  begin
    ready_d = 1'b0;  // Single-cycle pulse
    valid_d = valid_q;
    rdata_d = rdata_q;

    if (rd_accept)
    begin
      ready_d = 1'b1;
      valid_d = 1'b1;
      // Empty mailbox reads as zero, nothing is popped then
      rdata_d = pop_beat.tvalid ? pop_beat.tdata : '0;
    end
    else if (valid_q & rd_req.rready)
    begin
      valid_d = 1'b0;
    end
  end

  assign rd_rsp.arready = ready_q;
  assign rd_rsp.rvalid  = valid_q;
  assign rd_rsp.rdata   = rdata_q;
  assign rd_rsp.rresp   = OKAY;  // Reads never fail

  // FIFO only pops if its head is still valid
  assign pop_ready = ready_q;

endmodule

//--- hdl/axi_mailbox.sv
module axi_mailbox
  import mbox_pkg::*;
(
  input  logic                   aclk,
  input  logic                   aresetn,

  // Write port, each write pushes one word
  input  axil_wr_req_t           wr_req,
  output axil_wr_rsp_t           wr_rsp,

  // Read port, each read pops the oldest word
  input  axil_rd_req_t           rd_req,
  output axil_rd_rsp_t           rd_rsp,

  // Current number of buffered words
  output logic [COUNT_WIDTH-1:0] fill_count
);

  axis_beat_t push_beat;   // Writer to FIFO
  logic       push_ready;
  axis_beat_t pop_beat;    // FIFO to reader
  logic       pop_ready;

  // Write side
  axi_axis_writer writer_i (
    .aclk       (aclk),
    .aresetn    (aresetn),
    .wr_req     (wr_req),
    .wr_rsp     (wr_rsp),
    .push_beat  (push_beat),
    .push_ready (push_ready)
  );

  axis_fifo fifo_i (
    .aclk       (aclk),
    .aresetn    (aresetn),
    .push_beat  (push_beat),
    .push_ready (push_ready),
    .pop_beat   (pop_beat),
    .pop_ready  (pop_ready),
    .fill_count (fill_count)
  );

  // Read side
  axi_axis_reader reader_i (
    .aclk      (aclk),
    .aresetn   (aresetn),
    .rd_req    (rd_req),
    .rd_rsp    (rd_rsp),
    .pop_beat  (pop_beat),
    .pop_ready (pop_ready)
  );

endmodule

//--- tests/tb_axi_mailbox.sv
module tb_axi_mailbox
  import mbox_pkg::*;
();
  timeunit 1ns;
  timeprecision 100ps;

  logic                   aclk;
  logic                   aresetn;
  axil_wr_req_t           wr_req;
  axil_wr_rsp_t           wr_rsp;
  axil_rd_req_t           rd_req;
  axil_rd_rsp_t           rd_rsp;
  logic [COUNT_WIDTH-1:0] fill_count;

  logic [31:0] lfsr_state = 32'd79;
  logic [31:0] model_q[$];      // Words the mailbox should hold in write order
  string       test_name;
  int          errors = 0;
  int          timeouts = 0;
  int          max_wait = 50;   // Cycles any handshake may take

  axi_mailbox dut_i (
    .aclk       (aclk),
    .aresetn    (aresetn),
    .wr_req     (wr_req),
    .wr_rsp     (wr_rsp),
    .rd_req     (rd_req),
    .rd_rsp     (rd_rsp),
    .fill_count (fill_count)
  );

  initial
  begin
    aclk = 1'b0;
    forever #4 aclk = ~aclk;
  end

  // Taps for x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic random_bits(input int n, output logic [31:0] value);
    value = '0;
    for (int i = 0; i < n; i++)
    begin
      lfsr_state = lfsr_step(lfsr_state);
      value      = {value[30:0], lfsr_state[0]};
    end
  endtask

  task automatic check_value(input string what, input logic [31:0] expected,
                             input logic [31:0] actual);
    assert (actual === expected)
    else
    begin
      errors++;
      $display("ERR %s %s: expected %h, actual %h", test_name, what, expected, actual);
    end
  endtask

  task automatic report_timeout(input string what);
    timeouts++;
    $display("Timeout in %s: %s did not rise in time", test_name, what);
  endtask

  // Holds AW and W until awready, then releases them
  task automatic wait_awready();
    int n;
    n = 0;
    @(negedge aclk);
    while (!wr_rsp.awready && n < max_wait)
    begin
      @(negedge aclk);
      n++;
    end
    assert (wr_rsp.awready) else report_timeout("awready");
    check_value("wready", 32'd1, 32'(wr_rsp.wready));  // W accepted with AW
    wr_req.awvalid = 1'b0;
    wr_req.wvalid  = 1'b0;
  endtask

  task automatic take_bresp(output resp_e resp);
    int n;
    n = 0;
    while (!wr_rsp.bvalid && n < max_wait)
    begin
      @(negedge aclk);
      n++;
    end
    assert (wr_rsp.bvalid) else report_timeout("bvalid");
    resp          = wr_rsp.bresp;
    wr_req.bready = 1'b1;  // Accepted on the next rising edge
    @(negedge aclk);
    wr_req.bready = 1'b0;
  endtask

  task automatic wait_arready();
    int n;
    n = 0;
    @(negedge aclk);
    while (!rd_rsp.arready && n < max_wait)
    begin
      @(negedge aclk);
      n++;
    end
    assert (rd_rsp.arready) else report_timeout("arready");
    rd_req.arvalid = 1'b0;
  endtask

  task automatic take_rdata(output logic [31:0] data, output resp_e resp);
    int n;
    n = 0;
    while (!rd_rsp.rvalid && n < max_wait)
    begin
      @(negedge aclk);
      n++;
    end
    assert (rd_rsp.rvalid) else report_timeout("rvalid");
    data          = rd_rsp.rdata;
    resp          = rd_rsp.rresp;
    rd_req.rready = 1'b1;
    @(negedge aclk);
    rd_req.rready = 1'b0;
  endtask

  task automatic axil_write(input logic [31:0] data, output resp_e resp);
    wr_req.awvalid = 1'b1;
    wr_req.wvalid  = 1'b1;
    wr_req.wdata   = data;
    wait_awready();
    take_bresp(resp);
  endtask

  task automatic axil_read(output logic [31:0] data, output resp_e resp);
    rd_req.arvalid = 1'b1;
    wait_arready();
    take_rdata(data, resp);
  endtask

  // Write one word and compare with the queue model
  task automatic write_checked(input logic [31:0] data);
    resp_e resp;
    resp_e expected;
    if (model_q.size() < FIFO_DEPTH)
    begin
      expected = OKAY;
      model_q.push_back(data);
    end
    else
    begin
      expected = SLVERR;  // Full so the word is dropped
    end
    axil_write(data, resp);
    check_value("bresp", 32'(expected), 32'(resp));
    check_value("fill_count", 32'(model_q.size()), 32'(fill_count));
  endtask

  task automatic read_checked();
    logic [31:0] data;
    logic [31:0] expected;
    resp_e       resp;
    expected = (model_q.size() > 0) ? model_q.pop_front() : 32'd0;
    axil_read(data, resp);
    check_value("rdata", expected, data);
    check_value("rresp", 32'(OKAY), 32'(resp));
    check_value("fill_count", 32'(model_q.size()), 32'(fill_count));
  endtask

  task automatic reset_state();
    test_name = "reset_state";
    check_value("arready", 32'd0, 32'(rd_rsp.arready));
    check_value("rvalid", 32'd0, 32'(rd_rsp.rvalid));
    check_value("awready", 32'd0, 32'(wr_rsp.awready));
    check_value("wready", 32'd0, 32'(wr_rsp.wready));
    check_value("bvalid", 32'd0, 32'(wr_rsp.bvalid));
    check_value("fill_count", 32'd0, 32'(fill_count));
    read_checked();  // Empty mailbox reads as zero
  endtask

  task automatic in_order();
    logic [31:0] word;
    test_name = "in_order";
    repeat (8)
    begin
      random_bits(32, word);
      write_checked(word);
    end
    repeat (8) read_checked();
  endtask

  task automatic overflow_drop();
    logic [31:0] word;
    test_name = "overflow_drop";
    repeat (FIFO_DEPTH + 1)
    begin
      random_bits(32, word);
      write_checked(word);  // Last one gets SLVERR
    end
    repeat (FIFO_DEPTH + 1) read_checked();
  endtask

  task automatic read_backpressure();
    logic [31:0] word;
    logic [31:0] held;
    resp_e       resp;
    test_name = "read_backpressure";
    repeat (2)
    begin
      random_bits(32, word);
      write_checked(word);
    end
    rd_req.arvalid = 1'b1;
    wait_arready();
    held = rd_rsp.rdata;
    check_value("rdata", model_q[0], held);
    repeat (10)
    begin
      @(negedge aclk);
      check_value("rvalid held", 32'd1, 32'(rd_rsp.rvalid));
      check_value("rdata held", held, rd_rsp.rdata);
    end
    // Head word already left the FIFO even though rready is still low
    check_value("fill_count", 32'(model_q.size()) - 32'd1, 32'(fill_count));
    take_rdata(word, resp);
    check_value("rdata", model_q.pop_front(), word);
    check_value("rresp", 32'(OKAY), 32'(resp));
    read_checked();
  endtask

  task automatic write_backpressure();
    logic [31:0] first;
    logic [31:0] second;
    resp_e       resp;
    test_name = "write_backpressure";
    random_bits(32, first);
    random_bits(32, second);
    wr_req.awvalid = 1'b1;
    wr_req.wvalid  = 1'b1;
    wr_req.wdata   = first;
    wait_awready();
    wr_req.awvalid = 1'b1;  // Second write waits behind the held response
    wr_req.wvalid  = 1'b1;
    wr_req.wdata   = second;
    repeat (10)
    begin
      @(negedge aclk);
      check_value("awready blocked", 32'd0, 32'(wr_rsp.awready));
      check_value("bvalid held", 32'd1, 32'(wr_rsp.bvalid));
    end
    take_bresp(resp);
    check_value("bresp first", 32'(OKAY), 32'(resp));
    model_q.push_back(first);
    wait_awready();
    take_bresp(resp);
    check_value("bresp second", 32'(OKAY), 32'(resp));
    model_q.push_back(second);
    read_checked();
    read_checked();
  endtask

  task automatic random_mix();
    logic [31:0] pick;
    logic [31:0] word;
    test_name = "random_mix";
    repeat (40)
    begin
      random_bits(1, pick);  // One bit picks write or read
      if (pick[0])
      begin
        random_bits(32, word);
        write_checked(word);
      end
      else
      begin
        read_checked();
      end
    end
  endtask

  initial
  begin
    aresetn = 1'b0;
    wr_req  = '0;
    rd_req  = '0;
    repeat (5) @(negedge aclk);
    aresetn = 1'b1;
    @(negedge aclk);

    reset_state();
    in_order();
    overflow_drop();
    read_backpressure();
    write_backpressure();
    random_mix();

    $display("Errors: %0d value mismatches, %0d timeouts", errors, timeouts);
    if (errors == 0 && timeouts == 0)
    begin
      $display("Result: PASSED");
    end
    else
    begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

//--- sources.f
hdl/mbox_pkg.sv
hdl/axi_axis_writer.sv
hdl/axis_fifo.sv
hdl/axi_axis_reader.sv
hdl/axi_mailbox.sv
tests/tb_axi_mailbox.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the mailbox testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary -f sources.f --top-module tb_axi_mailbox
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

sim_output=$(./obj_dir/Vtb_axi_mailbox)
sim_status=$?
echo "$sim_output"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if grep -qx "Result: PASSED" <<< "$sim_output"; then
  exit 0
fi
exit 1
